//--- hdl/sine_pkg.sv
`default_nettype none

package sine_pkg;

    // One full sine cycle spans 2^PHASE_WIDTH.
    localparam int PHASE_WIDTH = 22;
    localparam int STEP_WIDTH = 20;
    localparam int SAMPLE_WIDTH = 16;
    localparam int TABLE_ADDR_WIDTH = 10;

    // Quarter-wave table.
    localparam int TABLE_DEPTH = 1024;
    localparam int SAMPLE_AMPLITUDE = 32767;

    // Clock cycles per sample period.
    localparam int SAMPLE_DIVIDE = 8;
    localparam int DIVIDE_COUNT_WIDTH = $clog2(SAMPLE_DIVIDE);

    localparam real PI = 3.14159265358979323846;

    typedef logic [PHASE_WIDTH-1:0] phase_t;
    typedef logic [STEP_WIDTH-1:0] step_t;
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [TABLE_ADDR_WIDTH-1:0] table_addr_t;
    typedef logic [DIVIDE_COUNT_WIDTH-1:0] divide_count_t;

endpackage

`default_nettype wire

//--- hdl/sine_rom.sv
`timescale 1ns/1ps
`default_nettype none

module sine_rom (
    input  wire logic               clk,
    input  wire sine_pkg::table_addr_t addr,
    output sine_pkg::sample_t       data
);

    import sine_pkg::*;

    sample_t table_mem [TABLE_DEPTH];

    // First quarter of a 4*TABLE_DEPTH point cycle.
    // Sampled half a step in, so entry i and entry 1023-i mirror exactly.
    initial begin : fill_table
        real angle;
        real value;

        for (int i = 0; i < TABLE_DEPTH; i++) begin
            angle = 2.0 * PI * (real'(i) + 0.5) / real'(4 * TABLE_DEPTH);
            value = $sin(angle) * real'(SAMPLE_AMPLITUDE);
            // All entries are positive, so truncation after +0.5 rounds.
            table_mem[i] = sample_t'($rtoi(value + 0.5));
        end
    end

    // Registered read.
    always_ff @(posedge clk) begin
        data <= table_mem[addr];
    end

endmodule

`default_nettype wire

//--- hdl/sine_reader.sv
`timescale 1ns/1ps
`default_nettype none

module sine_reader (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire sine_pkg::step_t       step_size,
    input  wire logic                  generate_next,
    output sine_pkg::table_addr_t      rom_addr,
    input  wire sine_pkg::sample_t     rom_data,
    output sine_pkg::sample_t          sample,
    output logic                       sample_ready
);

    import sine_pkg::*;

    phase_t phase;

    logic [1:0] quadrant;
    table_addr_t fine_index;

    // Stage 1 is the table read, stage 2 the sign restore.
    logic valid_d1;
    logic valid_d2;
    logic negate_d2;

    // Phase accumulator, advanced only on a request.
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
        end else if (generate_next) begin
            phase <= phase + phase_t'(step_size);
        end
    end

    assign quadrant = phase[PHASE_WIDTH-1 -: 2];
    assign fine_index = phase[PHASE_WIDTH-3 -: TABLE_ADDR_WIDTH];

    // Odd quadrants run the table backwards.
    assign rom_addr = quadrant[0] ? ~fine_index : fine_index;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_d1 <= 1'b0;
            valid_d2 <= 1'b0;
        end else begin
            valid_d1 <= generate_next;
            valid_d2 <= valid_d1;
        end
    end

    // Sign follows the table read by one stage.
    always_ff @(posedge clk) begin
        negate_d2 <= quadrant[1];
    end

    // Lower half of the cycle is the negated table value.
    always_ff @(posedge clk) begin
        if (reset) begin
            sample <= '0;
            sample_ready <= 1'b0;
        end else begin
            sample_ready <= valid_d2;
            if (valid_d2) begin
                sample <= negate_d2 ? sample_t'(-rom_data) : rom_data;
            end
        end
    end

    // Nothing is ready in the three cycles after reset.
    assert property (@(posedge clk)
        $fell(reset) |-> !sample_ready [*3])
        else $error("sample_ready high within three cycles of reset");

    // Address must be clean while the table read is in progress.
    assert property (@(posedge clk) disable iff (reset)
        valid_d1 |-> !$isunknown(rom_addr))
        else $error("rom_addr unknown during a table read");

endmodule

`default_nettype wire

//--- hdl/sample_strobe_gen.sv
`timescale 1ns/1ps
`default_nettype none

module sample_strobe_gen (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic enable,
    output logic      generate_next
);

    import sine_pkg::*;

    divide_count_t count;

    // Counts enabled cycles, pulses on the last one of each period.
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            generate_next <= 1'b0;
        end else if (!enable) begin
            // Restart always waits a full period.
            count <= '0;
            generate_next <= 1'b0;
        end else if (count == divide_count_t'(SAMPLE_DIVIDE - 1)) begin
            count <= '0;
            generate_next <= 1'b1;
        end else begin
            count <= count + 1'b1;
            generate_next <= 1'b0;
        end
    end

    // Pulses are at least one sample period apart.
    assert property (@(posedge clk) disable iff (reset)
        generate_next |=> !generate_next [*(SAMPLE_DIVIDE - 1)])
        else $error("generate_next pulses closer than SAMPLE_DIVIDE cycles");

endmodule

`default_nettype wire

//--- hdl/sine_synth.sv
`timescale 1ns/1ps
`default_nettype none

module sine_synth (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              enable,
    input  wire sine_pkg::step_t   step_size,
    output sine_pkg::sample_t      sample,
    output logic                   sample_ready
);

    import sine_pkg::*;

    logic generate_next;
    table_addr_t rom_addr;
    sample_t rom_data;

    // Sample rate request.
    sample_strobe_gen u_strobe (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .generate_next (generate_next)
    );

    sine_reader u_reader (
        .clk           (clk),
        .reset         (reset),
        .step_size     (step_size),
        .generate_next (generate_next),
        .rom_addr      (rom_addr),
        .rom_data      (rom_data),
        .sample        (sample),
        .sample_ready  (sample_ready)
    );

    // Quarter-wave table.
    sine_rom u_rom (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // Half of the 100 ns period.
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verif/sine_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sine_checker (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              enable,
    input  wire sine_pkg::step_t   step_size,
    input  wire sine_pkg::sample_t sample,
    input  wire logic              sample_ready,
    output int                     check_count,
    output int                     error_count
);

    import sine_pkg::*;

    int checks = 0;
    int errors = 0;
    int cycle = 0;
    int enabled_cycles = 0;
    logic armed = 1'b0;
    logic request = 1'b0;
    phase_t model_phase = '0;
    sample_t held = '0;

    // Results in flight and the cycle each one is due.
    sample_t expected_q[$];
    int due_q[$];

    assign check_count = checks;
    assign error_count = errors;

    // Quarter table lookup with mirror and sign by quadrant.
    function automatic sample_t expected_sample(input phase_t phase);
        logic [1:0] quadrant;
        int index;
        real angle;
        int magnitude;

        quadrant = phase[21:20];
        index = int'(phase[19:10]);
        if (quadrant[0]) begin
            index = TABLE_DEPTH - 1 - index;
        end
        angle = 2.0 * PI * (real'(index) + 0.5) / real'(4 * TABLE_DEPTH);
        magnitude = int'($sin(angle) * real'(SAMPLE_AMPLITUDE));
        if (quadrant[1]) begin
            return sample_t'(-magnitude);
        end
        return sample_t'(magnitude);
    endfunction

    // Compares outputs mid-cycle and reads inputs as the next edge sees them.
    always @(negedge clk) begin
        if (armed) begin
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                if (sample_ready !== 1'b1) begin
                    $display("ERROR at %0t: sample_ready missing three cycles after a request",
                             $time);
                    errors++;
                end else begin
                    checks++;
                    if (sample !== expected_q[0]) begin
                        $display("FAIL time=%0t signal=sample expected=%0d actual=%0d",
                                 $time, expected_q[0], sample);
                        errors++;
                    end
                end
                held = expected_q[0];
                void'(due_q.pop_front());
                void'(expected_q.pop_front());
            end else begin
                if (sample_ready !== 1'b0) begin
                    $display("ERROR at %0t: sample_ready pulsed with no request in flight",
                             $time);
                    errors++;
                end
                if (sample !== held) begin
                    $display("FAIL time=%0t signal=sample expected=%0d actual=%0d",
                             $time, held, sample);
                    errors++;
                end
            end
        end

        // Model state after the coming rising edge.
        if (reset) begin
            armed = 1'b1;
            enabled_cycles = 0;
            request = 1'b0;
            model_phase = '0;
            held = '0;
            due_q.delete();
            expected_q.delete();
        end else begin
            if (request) begin
                model_phase = model_phase + phase_t'(step_size);
                expected_q.push_back(expected_sample(model_phase));
                due_q.push_back(cycle + 3);
            end
            if (!enable) begin
                enabled_cycles = 0;
                request = 1'b0;
            end else begin
                enabled_cycles++;
                request = (enabled_cycles == SAMPLE_DIVIDE);
                if (request) begin
                    enabled_cycles = 0;
                end
            end
        end
        cycle++;
    end

endmodule

`default_nettype wire

//--- verif/sine_synth_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sine_synth_tb;

    import sine_pkg::*;

    localparam int SAMPLE_TIMEOUT = 64;
    localparam int RANDOM_STEPS = 40;

    logic clk;
    logic reset;
    logic enable;
    step_t step_size;
    sample_t sample;
    logic sample_ready;

    int check_count;
    int checker_errors;
    int local_errors = 0;
    int cycle_count = 0;
    int test_checks = 0;
    int test_errors = 0;
    logic timed_out = 1'b0;

    sample_t value;
    sample_t previous;
    sample_t quad [8];
    step_t step;
    int count;
    int pulse_cycle;
    int prev_cycle;
    int rise_cycle;
    int low_pulses;

    tb_clock u_clock (
        .clk (clk)
    );

    sine_synth dut (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .step_size    (step_size),
        .sample       (sample),
        .sample_ready (sample_ready)
    );

    sine_checker u_checker (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .step_size    (step_size),
        .sample       (sample),
        .sample_ready (sample_ready),
        .check_count  (check_count),
        .error_count  (checker_errors)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic drive_inputs(input logic en, input step_t new_step);
        @(posedge clk);
        enable <= en;
        step_size <= new_step;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    // Returns at the middle of the pulse cycle.
    task automatic wait_sample(output sample_t result, output int at_cycle);
        int waited;

        result = '0;
        at_cycle = 0;
        waited = 0;
        if (timed_out) begin
            return;
        end
        while (waited < SAMPLE_TIMEOUT) begin
            @(negedge clk);
            if (sample_ready === 1'b1) begin
                result = sample;
                at_cycle = cycle_count;
                return;
            end
            waited++;
        end
        $display("Timeout: no sample_ready within %0d cycles at %0t", SAMPLE_TIMEOUT, $time);
        timed_out = 1'b1;
    endtask

    task automatic count_low_pulses(input int cycles, output int pulses);
        pulses = 0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (sample_ready !== 1'b0) begin
                pulses++;
            end
        end
    endtask

    task automatic start_test();
        test_checks = check_count;
        test_errors = checker_errors + local_errors;
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        $display("%s: %0d samples checked, %0d errors", name,
                 check_count - test_checks, checker_errors + local_errors - test_errors);
    endtask

    task automatic report_mismatch(input string signal, input int expected, input int actual);
        $display("FAIL time=%0t signal=%s expected=%0d actual=%0d",
                 $time, signal, expected, actual);
        local_errors++;
    endtask

    initial begin
        reset = 1'b1;
        enable = 1'b0;
        step_size = '0;
        void'($urandom(32'h454f));
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        start_test();
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            if (sample_ready !== 1'b0) begin
                $display("ERROR at %0t: sample_ready pulsed while idle", $time);
                local_errors++;
            end
            if (sample !== '0) begin
                report_mismatch("sample", 0, sample);
            end
        end
        finish_test("reset_idle");

        // 256 steps of 2^14 make one full cycle.
        start_test();
        drive_inputs(1'b1, 20'h04000);
        for (int i = 0; i < 256; i++) begin
            wait_sample(value, pulse_cycle);
            if (i > 0 && !timed_out && pulse_cycle - prev_cycle != SAMPLE_DIVIDE) begin
                report_mismatch("sample_ready spacing", SAMPLE_DIVIDE, pulse_cycle - prev_cycle);
            end
            prev_cycle = pulse_cycle;
        end
        finish_test("fixed_step");

        // Eighth-cycle steps from zero phase land on every quadrant start.
        start_test();
        drive_inputs(1'b1, 20'h80000);
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            wait_sample(quad[i], pulse_cycle);
        end
        if (!timed_out && quad[3] !== sample_t'(-quad[7])) begin
            report_mismatch("sample", sample_t'(-quad[7]), quad[3]);
        end
        if (!timed_out && quad[5] !== sample_t'(-quad[1])) begin
            report_mismatch("sample", sample_t'(-quad[1]), quad[5]);
        end
        finish_test("quadrants");

        start_test();
        previous = quad[7];
        drive_inputs(1'b1, '0);
        for (int i = 0; i < 6; i++) begin
            wait_sample(value, pulse_cycle);
            if (!timed_out && value !== previous) begin
                report_mismatch("sample", previous, value);
            end
            previous = value;
        end
        finish_test("zero_step");

        start_test();
        for (int i = 0; i < RANDOM_STEPS; i++) begin
            step = step_t'($urandom);
            count = 1 + int'($urandom % 6);
            drive_inputs(1'b1, step);
            for (int j = 0; j < count; j++) begin
                wait_sample(value, pulse_cycle);
            end
        end
        finish_test("random_steps");

        start_test();
        drive_inputs(1'b0, step_size);
        count_low_pulses(20, low_pulses);
        if (low_pulses != 0) begin
            $display("ERROR at %0t: %0d pulses while enable was low", $time, low_pulses);
            local_errors++;
        end
        drive_inputs(1'b1, 20'h12345);
        @(negedge clk);
        rise_cycle = cycle_count;
        wait_sample(value, pulse_cycle);
        if (!timed_out && pulse_cycle - rise_cycle != SAMPLE_DIVIDE + 3) begin
            report_mismatch("sample_ready latency", SAMPLE_DIVIDE + 3, pulse_cycle - rise_cycle);
        end
        for (int i = 0; i < 4; i++) begin
            wait_sample(value, pulse_cycle);
        end
        finish_test("enable_gap");

        $display("Summary: %0d samples checked, %0d errors%s", check_count,
                 checker_errors + local_errors, timed_out ? ", run stopped by timeout" : "");
        if (timed_out || checker_errors + local_errors > 0) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sine_synth.f
hdl/sine_pkg.sv
hdl/sine_rom.sv
hdl/sine_reader.sv
hdl/sample_strobe_gen.sv
hdl/sine_synth.sv
verif/tb_clock.sv
verif/sine_checker.sv
verif/sine_synth_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the sine_synth testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

rm -rf "${BUILD_DIR}"

verilator --binary --timing --assert -Wno-fatal \
    --top-module sine_synth_tb \
    --Mdir "${BUILD_DIR}" \
    -o sine_synth_sim \
    -f sine_synth.f

"./${BUILD_DIR}/sine_synth_sim" 2>&1 | tee "${LOG_FILE}"

if grep -q "Testbench failed" "${LOG_FILE}"; then
    echo "Simulation reported failure, see ${LOG_FILE}"
    exit 1
fi

echo "Simulation finished without failure"
